//--- rtl/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int N_CHAN  = 3;
  localparam int N_BANK  = 4;
  localparam int MAX_BUF = 8;  // deepest ring the entry id can address

  // --------------------
  // vector types
  // --------------------
  typedef logic [1:0]         chan_id_t;
  typedef logic [1:0]         bank_addr_t;
  typedef logic [2:0]         entry_id_t;
  typedef logic [MAX_BUF-1:0] entry_mask_t;  // only low BUFFER_SIZE bits live
  typedef logic [N_CHAN-1:0]  chan_mask_t;
  typedef logic [N_BANK-1:0]  bank_mask_t;

  // --------------------
  // structs
  // --------------------
  // request as offered by a channel
  typedef struct packed {
    logic       valid;
    bank_addr_t addr;
  } xbar_req_t;

  // grant a bank hands out this cycle
  typedef struct packed {
    logic      valid;
    chan_id_t  ch_id;     // winning channel
    entry_id_t entry_id;  // its buffer slot
  } bank_grant_t;

endpackage

`default_nettype wire

//--- rtl/chan_entry_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module chan_entry_buffer
  import xbar_pkg::*;
#(
  parameter int BUFFER_SIZE = 5
) (
  input  wire logic                     clk_i,
  input  wire logic                     rstn_i,
  input  wire xbar_req_t                req_i,
  input  wire bank_mask_t               bank_gnt_i,
  input  wire entry_id_t [N_BANK-1:0]   pick_id_i,
  output logic                          allow_o,
  output entry_mask_t [N_BANK-1:0]      bank_marks_o,
  output entry_id_t                     read_ptr_o
);

  localparam int CNT_W = $clog2(MAX_BUF + 1);

  entry_id_t                wr_ptr_q;
  entry_id_t                rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic [CNT_W-1:0]         count_d;
  entry_mask_t [N_BANK-1:0] marks_q;
  entry_mask_t [N_BANK-1:0] marks_d;
  logic                     push;
  logic                     pop;
  logic                     head_busy;

  // --------------------
  // push / pop
  // --------------------
  assign allow_o = count_q != CNT_W'(BUFFER_SIZE);  // full stalls the source
  assign push    = req_i.valid & allow_o;

  // head slot still owed to some bank?
  always_comb begin
    head_busy = 1'b0;
    for (int b = 0; b < N_BANK; b++) begin
      head_busy = head_busy | marks_q[b][rd_ptr_q];
    end
  end

  assign pop = (count_q != '0) & ~head_busy;  // free in order only

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (!push && pop) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == entry_id_t'(BUFFER_SIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == entry_id_t'(BUFFER_SIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
    end
  end

  // --------------------
  // per-bank marks
  // --------------------
  always_comb begin
    marks_d = marks_q;
    for (int b = 0; b < N_BANK; b++) begin
      if (bank_gnt_i[b]) begin
        marks_d[b][pick_id_i[b]] = 1'b0;  // served this cycle
      end
    end
    // write slot is free, so no clash with a clear above
    if (push) begin
      marks_d[req_i.addr][wr_ptr_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      marks_q <= '0;
    end else begin
      marks_q <= marks_d;
    end
  end

  assign bank_marks_o = marks_q;
  assign read_ptr_o   = rd_ptr_q;

  // --------------------
  // checks
  // --------------------
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
    count_q <= CNT_W'(BUFFER_SIZE));

  for (genvar b = 0; b < N_BANK; b++) begin : g_chk
    // arbiter and picker must agree with the stored marks
    a_gnt_marked: assert property (@(posedge clk_i) disable iff (!rstn_i)
      bank_gnt_i[b] |-> marks_q[b][pick_id_i[b]]);
  end

endmodule

`default_nettype wire

//--- rtl/oldest_entry_pick.sv
`timescale 1ns/10ps
`default_nettype none

module oldest_entry_pick
  import xbar_pkg::*;
#(
  parameter int BUFFER_SIZE = 5
) (
  input  wire entry_mask_t [N_BANK-1:0] bank_marks_i,
  input  wire entry_id_t                read_ptr_i,
  output bank_mask_t                    want_o,
  output entry_id_t [N_BANK-1:0]        pick_id_o
);

  // ring index base + off, wrapping at BUFFER_SIZE
  function automatic entry_id_t ring_add(entry_id_t base, int unsigned off);
    int unsigned sum;
    sum = int'(base) + off;
    if (sum >= BUFFER_SIZE) begin
      sum = sum - BUFFER_SIZE;
    end
    return entry_id_t'(sum);
  endfunction

  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    entry_mask_t rot_marks;  // bit 0 is the read pointer slot
    entry_id_t   first_off;

    always_comb begin
      rot_marks = '0;
      for (int i = 0; i < BUFFER_SIZE; i++) begin
        rot_marks[i] = bank_marks_i[b][ring_add(read_ptr_i, i)];
      end
    end

    // lowest set offset wins, i.e. oldest entry
    always_comb begin
      first_off = '0;
      for (int i = BUFFER_SIZE - 1; i >= 0; i--) begin
        if (rot_marks[i]) begin
          first_off = entry_id_t'(i);
        end
      end
    end

    assign want_o[b]    = |bank_marks_i[b];
    assign pick_id_o[b] = ring_add(read_ptr_i, first_off);  // back to absolute slot
  end

endmodule

`default_nettype wire

//--- rtl/bank_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bank_arbiter
  import xbar_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rstn_i,
  input  wire chan_mask_t             want_i,
  input  wire entry_id_t [N_CHAN-1:0] entry_id_i,
  output chan_mask_t                  gnt_o,
  output bank_grant_t                 grant_o
);

  chan_id_t last_q;   // channel served most recently
  chan_id_t win_id;
  logic     any_want;

  assign any_want = |want_i;

  // --------------------
  // round robin search
  // --------------------
  always_comb begin
    int unsigned cand;
    logic        found;
    win_id = last_q;
    found  = 1'b0;
    // start just past the last winner, wrap around
    for (int i = 1; i <= N_CHAN; i++) begin
      cand = (int'(last_q) + i) % N_CHAN;
      if (!found && want_i[cand]) begin
        found  = 1'b1;
        win_id = chan_id_t'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (any_want) begin
      gnt_o[win_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      last_q <= chan_id_t'(N_CHAN - 1);  // channel 0 goes first
    end else if (any_want) begin
      last_q <= win_id;
    end
  end

  // grant level, no handshake
  always_comb begin
    grant_o          = '0;
    grant_o.valid    = any_want;
    if (any_want) begin
      grant_o.ch_id    = win_id;
      grant_o.entry_id = entry_id_i[win_id];
    end
  end

  // --------------------
  // checks
  // --------------------
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $onehot0(gnt_o));

  a_gnt_wanted: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (gnt_o & ~want_i) == '0);

endmodule

`default_nettype wire

//--- rtl/xbar_top.sv
`timescale 1ns/10ps
`default_nettype none

module xbar_top
  import xbar_pkg::*;
#(
  parameter int BUFFER_SIZE = 5
) (
  input  wire logic                     clk_i,
  input  wire logic                     rstn_i,
  input  wire xbar_req_t [N_CHAN-1:0]   req_i,
  output chan_mask_t                    allow_o,
  output bank_grant_t [N_BANK-1:0]      grant_o
);

  // per channel view
  entry_mask_t [N_BANK-1:0] bank_marks [N_CHAN];
  entry_id_t                read_ptr   [N_CHAN];
  bank_mask_t               chan_want  [N_CHAN];
  entry_id_t [N_BANK-1:0]   chan_pick  [N_CHAN];
  bank_mask_t               chan_gnt   [N_CHAN];

  // per bank view
  chan_mask_t               bank_want  [N_BANK];
  entry_id_t [N_CHAN-1:0]   bank_pick  [N_BANK];
  chan_mask_t               bank_gnt   [N_BANK];

  // --------------------
  // channels
  // --------------------
  for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
    chan_entry_buffer #(
      .BUFFER_SIZE (BUFFER_SIZE)
    ) u_buf (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .req_i        (req_i[c]),
      .bank_gnt_i   (chan_gnt[c]),
      .pick_id_i    (chan_pick[c]),
      .allow_o      (allow_o[c]),
      .bank_marks_o (bank_marks[c]),
      .read_ptr_o   (read_ptr[c])
    );

    oldest_entry_pick #(
      .BUFFER_SIZE (BUFFER_SIZE)
    ) u_pick (
      .bank_marks_i (bank_marks[c]),
      .read_ptr_i   (read_ptr[c]),
      .want_o       (chan_want[c]),
      .pick_id_o    (chan_pick[c])
    );
  end

  // --------------------
  // channel <-> bank transpose
  // --------------------
  for (genvar b = 0; b < N_BANK; b++) begin : g_xpose_b
    for (genvar c = 0; c < N_CHAN; c++) begin : g_xpose_c
      assign bank_want[b][c] = chan_want[c][b];
      assign bank_pick[b][c] = chan_pick[c][b];
      assign chan_gnt[c][b]  = bank_gnt[b][c];  // back to the owning channel
    end
  end

  // --------------------
  // banks
  // --------------------
  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    bank_arbiter u_arb (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .want_i     (bank_want[b]),
      .entry_id_i (bank_pick[b]),
      .gnt_o      (bank_gnt[b]),
      .grant_o    (grant_o[b])
    );
  end

endmodule

`default_nettype wire

//--- testbench/xbar_tb_cases.svh
`ifndef XBAR_TB_CASES_SVH
`define XBAR_TB_CASES_SVH
`default_nettype none

// how each request picks its bank
typedef enum int {PAT_FIXED, PAT_MIXED, PAT_RAND} bank_pat_e;

typedef struct {
  string           name;
  logic [2:0][7:0] n_req;       // requests per channel
  bank_pat_e       pat;
  int              bank;        // bank for PAT_FIXED
  bit              rand_valid;  // random gaps between requests
  int              exp_lat;     // grant latency in cycles, -1 skips
  bit              exp_full;    // allow must drop at some point
  bit              exp_multi;   // some cycle has two or more grants
  int              settle;      // quiet cycles after drain
} tb_case_t;

localparam int N_CASES = 6;

function automatic tb_case_t make_case(string name, int n0, int n1, int n2, bank_pat_e pat,
                                       int bank, bit rand_valid, int exp_lat, bit exp_full,
                                       bit exp_multi, int settle);
  tb_case_t r;
  r.name       = name;
  r.n_req      = {8'(n2), 8'(n1), 8'(n0)};
  r.pat        = pat;
  r.bank       = bank;
  r.rand_valid = rand_valid;
  r.exp_lat    = exp_lat;
  r.exp_full   = exp_full;
  r.exp_multi  = exp_multi;
  r.settle     = settle;
  return r;
endfunction

// name, ch0 ch1 ch2 counts, pattern, bank, rand valid, latency, full, multi, settle
function automatic tb_case_t case_row(int idx);
  case (idx)
    0: return make_case("reset_state",    0,  0,  0, PAT_FIXED, 0, 0, -1, 0, 0, 10);
    1: return make_case("single_latency", 0,  1,  0, PAT_FIXED, 2, 0,  1, 0, 0, 3);
    2: return make_case("bank_order",     7,  0,  0, PAT_FIXED, 3, 0, -1, 0, 0, 3);
    3: return make_case("round_robin",    8,  8,  8, PAT_MIXED, 0, 0, -1, 0, 1, 3);
    4: return make_case("back_pressure", 12, 12, 12, PAT_FIXED, 1, 0, -1, 1, 0, 3);
    default: return make_case("random_traffic", 20, 20, 20, PAT_RAND, 0, 1, -1, 0, 0, 4);
  endcase
endfunction

function automatic logic [31:0] xorshift32(logic [31:0] x);
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

`default_nettype wire
`endif

//--- testbench/xbar_tb.sv
`timescale 1ns/10ps
`include "xbar_tb_cases.svh"
`default_nettype none

module xbar_tb
  import xbar_pkg::*;
();

  localparam int BUFFER_SIZE = 5;
  localparam int TIMEOUT     = 500;  // cycles per test

  logic                     clk_i;
  logic                     rstn_i;
  xbar_req_t [N_CHAN-1:0]   req_i;
  chan_mask_t               allow_o;
  bank_grant_t [N_BANK-1:0] grant_o;

  int          sb_q [N_CHAN][N_BANK][$];  // accept cycle * 16 + entry id
  int          wr_cnt [N_CHAN];
  int          rr_last [N_BANK];           // model of each arbiter's last winner
  xbar_req_t   cur_req [N_CHAN];
  logic        take [N_CHAN];
  int          left [N_CHAN];
  int          sent [N_CHAN];
  int          gnt_cnt [N_CHAN];           // grants seen per channel
  logic [31:0] rng;
  int          cyc;
  int          err_cnt;
  int          n_run;
  logic        timed_out;
  tb_case_t    cur;
  logic        saw_full;
  int          max_par;
  chan_mask_t  allow_seen;

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  xbar_top #(
    .BUFFER_SIZE (BUFFER_SIZE)
  ) dut_i (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .req_i   (req_i),
    .allow_o (allow_o),
    .grant_o (grant_o)
  );

  task automatic compare_value(string what, int exp, int act);
    if (exp != act) begin
      err_cnt++;
      $display("Error: test %s, %s: expected %0d, actual %0d", cur.name, what, exp, act);
    end
  endtask

  function automatic int next_bank(int c);
    case (cur.pat)
      PAT_FIXED: return cur.bank;
      PAT_MIXED: return (sent[c] % 2 == 0) ? 0 : c + 1;  // odd ones go uncontended
      default: begin
        rng = xorshift32(rng);
        return int'(rng[9:8]);
      end
    endcase
  endfunction

  function automatic logic traffic_pending();
    logic busy;
    busy = 1'b0;
    for (int c = 0; c < N_CHAN; c++) begin
      busy |= (left[c] > 0) | cur_req[c].valid;
      for (int b = 0; b < N_BANK; b++) begin
        busy |= sb_q[c][b].size() > 0;
      end
    end
    return busy;
  endfunction

  // --------------------
  // scoreboard
  // --------------------
  task automatic check_grants();
    int   par;
    int   exp_ch;
    int   head;
    logic exp_valid;
    par = 0;
    for (int b = 0; b < N_BANK; b++) begin
      exp_valid = 1'b0;
      exp_ch    = 0;
      // first channel past the last winner that still has work here
      for (int i = 1; i <= N_CHAN; i++) begin
        if (!exp_valid && sb_q[(rr_last[b] + i) % N_CHAN][b].size() > 0) begin
          exp_valid = 1'b1;
          exp_ch    = (rr_last[b] + i) % N_CHAN;
        end
      end
      compare_value($sformatf("bank %0d valid", b), int'(exp_valid), int'(grant_o[b].valid));
      if (grant_o[b].valid && grant_o[b].ch_id < N_CHAN) begin
        gnt_cnt[grant_o[b].ch_id]++;
      end
      if (exp_valid && grant_o[b].valid) begin
        head       = sb_q[exp_ch][b].pop_front();
        rr_last[b] = exp_ch;
        par++;
        compare_value($sformatf("bank %0d ch_id", b), exp_ch, int'(grant_o[b].ch_id));
        compare_value($sformatf("bank %0d entry_id", b), head % 16,
                      int'(grant_o[b].entry_id));
        if (cur.exp_lat >= 0) begin
          compare_value($sformatf("bank %0d latency", b), cur.exp_lat, cyc - head / 16);
        end
      end
    end
    if (par > max_par) max_par = par;
  endtask

  // --------------------
  // one clock cycle
  // --------------------
  task automatic step_cycle();
    @(negedge clk_i);
    check_grants();
    allow_seen = allow_o;
    for (int c = 0; c < N_CHAN; c++) begin
      take[c] = req_i[c].valid & allow_o[c];  // taken at the coming edge
      if (!allow_o[c]) saw_full = 1'b1;
    end
    @(posedge clk_i);
    cyc++;
    for (int c = 0; c < N_CHAN; c++) begin
      if (take[c]) begin
        sb_q[c][cur_req[c].addr].push_back((cyc - 1) * 16 + wr_cnt[c]);
        wr_cnt[c] = (wr_cnt[c] + 1) % BUFFER_SIZE;
        cur_req[c].valid = 1'b0;
      end
      if (!cur_req[c].valid && left[c] > 0) begin
        rng = xorshift32(rng);
        if (!cur.rand_valid || rng[4]) begin
          cur_req[c].addr  = bank_addr_t'(next_bank(c));
          cur_req[c].valid = 1'b1;
          left[c]--;
          sent[c]++;
        end
      end
      req_i[c] <= cur_req[c];
    end
  endtask

  task automatic run_case(int idx);
    int errs_before;
    int waited;
    cur         = case_row(idx);
    errs_before = err_cnt;
    saw_full    = 1'b0;
    max_par     = 0;
    for (int c = 0; c < N_CHAN; c++) begin
      left[c]    = int'(cur.n_req[c]);
      sent[c]    = 0;
      gnt_cnt[c] = 0;
    end
    waited = 0;
    while (traffic_pending() && waited < TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (traffic_pending()) begin
      $display("test %s timed out after %0d cycles, requests still outstanding",
               cur.name, waited);
      err_cnt++;
      timed_out = 1'b1;
    end
    repeat (cur.settle) step_cycle();
    for (int c = 0; c < N_CHAN; c++) begin
      compare_value($sformatf("ch %0d granted", c), int'(cur.n_req[c]), gnt_cnt[c]);
    end
    compare_value("allow after drain", 7, int'(allow_seen));
    if (cur.exp_full) compare_value("allow dropped", 1, int'(saw_full));
    if (cur.exp_multi) compare_value("parallel grants", 1, int'(max_par >= 2));
    n_run++;
    $display("test %s done, %0d errors", cur.name, err_cnt - errs_before);
  endtask

  initial begin
    rstn_i    = 1'b0;
    req_i     = '0;
    cyc       = 0;
    err_cnt   = 0;
    n_run     = 0;
    timed_out = 1'b0;
    rng       = 32'h0479a4a3;
    for (int c = 0; c < N_CHAN; c++) begin
      wr_cnt[c]  = 0;
      cur_req[c] = '0;
    end
    for (int b = 0; b < N_BANK; b++) begin
      rr_last[b] = N_CHAN - 1;
    end
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
    for (int i = 0; i < N_CASES && !timed_out; i++) begin
      run_case(i);
    end
    $display("%0d tests run, %0d errors", n_run, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+testbench
rtl/xbar_pkg.sv
rtl/chan_entry_buffer.sv
rtl/oldest_entry_pick.sv
rtl/bank_arbiter.sv
rtl/xbar_top.sv
testbench/xbar_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= xbar_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "result: PASS"; \
	else \
	  echo "result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
